/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // fetch address width
  localparam int ADDR_W = 32;

  // one fetch block is 16 bytes
  localparam int BLOCK_SHIFT = 4;

  typedef logic [ADDR_W-1:0] addr_t;

  // where the current fetch address came from
  typedef enum logic [1:0] {
    src_seq  = 2'd0,
    src_way0 = 2'd1,
    src_way1 = 2'd2
  } next_src_e;

  // byte step between consecutive blocks
  localparam addr_t BLOCK_BYTES = addr_t'(1) << BLOCK_SHIFT;

  // block number of an address, offset bits dropped
  function automatic logic [31:0] block_of(addr_t ip);
    return 32'(ip >> BLOCK_SHIFT);
  endfunction

endpackage

`default_nettype wire

/* hdl/predict_pkg.sv */
`default_nettype none

package predict_pkg;
  import fetch_pkg::*;

  // global history length
  localparam int HIST_W = 14;

  typedef logic [HIST_W-1:0] hist_t;

  // bit 0 picks the way-0 target, bit 1 the way-1 target
  typedef logic [1:0] pred_t;

  // table flipped by the next mispredict
  typedef enum logic [1:0] {
    tbl_a = 2'd0,
    tbl_b = 2'd1,
    tbl_c = 2'd2
  } tbl_sel_e;

  function automatic logic [31:0] idx_mask(int unsigned w);
    return (32'h1 << w) - 32'h1;
  endfunction

  // mostly address, 2 history bits at the bottom
  function automatic logic [31:0] index_a(addr_t ip, hist_t ght, int unsigned w);
    return ((block_of(ip) << 2) | 32'(ght[1:0])) & idx_mask(w);
  endfunction

  // even split of address and history
  function automatic logic [31:0] index_b(addr_t ip, hist_t ght, int unsigned w);
    int unsigned ha;
    int unsigned hh;
    ha = w / 2;
    hh = w - ha;
    return ((block_of(ip) & idx_mask(ha)) << hh) | (32'(ght) & idx_mask(hh));
  endfunction

  // 2 address bits, rest is history
  function automatic logic [31:0] index_c(addr_t ip, hist_t ght, int unsigned w);
    return ((block_of(ip) & 32'h3) << (w - 2)) | (32'(ght) & idx_mask(w - 2));
  endfunction

endpackage

`default_nettype wire

/* hdl/dir_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module dir_predictor
  import fetch_pkg::*;
  import predict_pkg::*;
#(
  parameter int PRED_IDX_W = 10
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire addr_t cur_ip,
  input  wire hist_t cur_ght,
  input  wire logic  retire_valid,
  input  wire logic  retire_mispred,
  input  wire addr_t retire_ip,
  input  wire hist_t retire_ght,
  input  wire logic  retire_way,
  output pred_t      pred
);

  localparam int DEPTH = 2 ** PRED_IDX_W;
  localparam int NUM_TBL = 3;

  // tables a, b, c stacked in one array
  pred_t mem [NUM_TBL][DEPTH];

  logic [PRED_IDX_W-1:0] rd_idx [NUM_TBL];
  logic [PRED_IDX_W-1:0] wr_idx [NUM_TBL];

  tbl_sel_e rot;
  pred_t    flip;
  logic     do_flip;

  // fetch side hashes
  assign rd_idx[0] = PRED_IDX_W'(index_a(cur_ip, cur_ght, PRED_IDX_W));
  assign rd_idx[1] = PRED_IDX_W'(index_b(cur_ip, cur_ght, PRED_IDX_W));
  assign rd_idx[2] = PRED_IDX_W'(index_c(cur_ip, cur_ght, PRED_IDX_W));

  // retire side uses the history seen at fetch time
  assign wr_idx[0] = PRED_IDX_W'(index_a(retire_ip, retire_ght, PRED_IDX_W));
  assign wr_idx[1] = PRED_IDX_W'(index_b(retire_ip, retire_ght, PRED_IDX_W));
  assign wr_idx[2] = PRED_IDX_W'(index_c(retire_ip, retire_ght, PRED_IDX_W));

  assign pred = mem[0][rd_idx[0]] ^ mem[1][rd_idx[1]] ^ mem[2][rd_idx[2]];

  assign do_flip = retire_valid && retire_mispred;
  assign flip = retire_way ? 2'b10 : 2'b01;

  // flipping one table always flips the xor
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < NUM_TBL; t++) begin
        for (int i = 0; i < DEPTH; i++) begin
          mem[t][i] <= '0;
        end
      end
    end else if (do_flip) begin
      mem[rot][wr_idx[rot]] <= mem[rot][wr_idx[rot]] ^ flip;
    end
  end

  // round robin a, b, c
  always_ff @(posedge clk) begin
    if (rst) begin
      rot <= tbl_a;
    end else if (do_flip) begin
      case (rot)
        tbl_a:   rot <= tbl_b;
        tbl_b:   rot <= tbl_c;
        default: rot <= tbl_a;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module target_buffer
  import fetch_pkg::*;
#(
  parameter int TB_IDX_W = 6
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire addr_t cur_ip,
  input  wire logic  retire_valid,
  input  wire addr_t retire_ip,
  input  wire logic  retire_way,
  input  wire addr_t retire_target,
  output logic       hit0,
  output logic       hit1,
  output addr_t      target0,
  output addr_t      target1
);

  localparam int DEPTH = 2 ** TB_IDX_W;
  localparam int TAG_W = ADDR_W - BLOCK_SHIFT - TB_IDX_W;

  logic             way_valid  [2][DEPTH];
  logic [TAG_W-1:0] way_tag    [2][DEPTH];
  addr_t            way_target [2][DEPTH];

  logic [TB_IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0]    rd_tag;
  logic [TB_IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0]    wr_tag;

  // index from block bits, tag is everything above
  assign rd_idx = cur_ip[BLOCK_SHIFT +: TB_IDX_W];
  assign rd_tag = cur_ip[ADDR_W-1 -: TAG_W];
  assign wr_idx = retire_ip[BLOCK_SHIFT +: TB_IDX_W];
  assign wr_tag = retire_ip[ADDR_W-1 -: TAG_W];

  assign hit0 = way_valid[0][rd_idx] && (way_tag[0][rd_idx] == rd_tag);
  assign hit1 = way_valid[1][rd_idx] && (way_tag[1][rd_idx] == rd_tag);
  assign target0 = way_target[0][rd_idx];
  assign target1 = way_target[1][rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < 2; w++) begin
        for (int i = 0; i < DEPTH; i++) begin
          way_valid[w][i] <= 1'b0;
        end
      end
    end else if (retire_valid) begin
      way_valid[retire_way][wr_idx] <= 1'b1;
    end
  end

  // tag and target only matter once valid is set
  always_ff @(posedge clk) begin
    if (retire_valid) begin
      way_tag[retire_way][wr_idx]    <= wr_tag;
      way_target[retire_way][wr_idx] <= retire_target;
    end
  end

endmodule

`default_nettype wire

/* hdl/next_ip_select.sv */
`timescale 1ns/1ps
`default_nettype none

module next_ip_select
  import fetch_pkg::*;
  import predict_pkg::*;
#(
  parameter addr_t RESET_IP = 32'h0000_1000
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  fetch_adv,
  input  wire pred_t pred,
  input  wire logic  hit0,
  input  wire logic  hit1,
  input  wire addr_t target0,
  input  wire addr_t target1,
  input  wire logic  retire_valid,
  input  wire logic  retire_mispred,
  input  wire addr_t retire_target,
  input  wire hist_t retire_ght,
  output addr_t      cur_ip,
  output hist_t      cur_ght,
  output next_src_e  fetch_src
);

  addr_t     ip_q;
  hist_t     ght_q;
  next_src_e src_q;

  addr_t     nxt_ip;
  hist_t     nxt_ght;
  next_src_e nxt_src;

  logic take0;
  logic take1;
  logic redirect;

  // a predicted jump only counts with a tag hit
  assign take0 = pred[0] && hit0;
  assign take1 = pred[1] && hit1;
  assign redirect = retire_valid && retire_mispred;

  always_comb begin
    if (take0) begin
      nxt_ip  = target0;
      nxt_ght = {ght_q[HIST_W-2:0], 1'b1};
      nxt_src = src_way0;
    end else if (take1) begin
      nxt_ip  = target1;
      nxt_ght = {ght_q[HIST_W-3:0], 2'b01};
      nxt_src = src_way1;
    end else begin
      nxt_ip  = ip_q + BLOCK_BYTES;
      nxt_ght = {ght_q[HIST_W-3:0], 2'b00};
      nxt_src = src_seq;
    end
  end

  // mispredict wins over fetch_adv
  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q  <= RESET_IP;
      ght_q <= '0;
      src_q <= src_seq;
    end else if (redirect) begin
      ip_q  <= retire_target;
      ght_q <= retire_ght;
      src_q <= src_seq;
    end else if (fetch_adv) begin
      ip_q  <= nxt_ip;
      ght_q <= nxt_ght;
      src_q <= nxt_src;
    end
  end

  assign cur_ip = ip_q;
  assign cur_ght = ght_q;
  assign fetch_src = src_q;

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
  import predict_pkg::*;
#(
  parameter int    PRED_IDX_W = 10,
  parameter int    TB_IDX_W   = 6,
  parameter addr_t RESET_IP   = 32'h0000_1000
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  fetch_adv,
  input  wire logic  retire_valid,
  input  wire addr_t retire_ip,
  input  wire hist_t retire_ght,
  input  wire logic  retire_way,
  input  wire addr_t retire_target,
  input  wire logic  retire_mispred,
  output addr_t      fetch_ip,
  output hist_t      fetch_ght,
  output next_src_e  fetch_src
);

  addr_t cur_ip;
  hist_t cur_ght;
  pred_t pred;
  logic  hit0;
  logic  hit1;
  addr_t target0;
  addr_t target1;

  dir_predictor #(
    .PRED_IDX_W(PRED_IDX_W)
  ) u_pred (
    .clk           (clk),
    .rst           (rst),
    .cur_ip        (cur_ip),
    .cur_ght       (cur_ght),
    .retire_valid  (retire_valid),
    .retire_mispred(retire_mispred),
    .retire_ip     (retire_ip),
    .retire_ght    (retire_ght),
    .retire_way    (retire_way),
    .pred          (pred)
  );

  target_buffer #(
    .TB_IDX_W(TB_IDX_W)
  ) u_tbuf (
    .clk          (clk),
    .rst          (rst),
    .cur_ip       (cur_ip),
    .retire_valid (retire_valid),
    .retire_ip    (retire_ip),
    .retire_way   (retire_way),
    .retire_target(retire_target),
    .hit0         (hit0),
    .hit1         (hit1),
    .target0      (target0),
    .target1      (target1)
  );

  next_ip_select #(
    .RESET_IP(RESET_IP)
  ) u_sel (
    .clk           (clk),
    .rst           (rst),
    .fetch_adv     (fetch_adv),
    .pred          (pred),
    .hit0          (hit0),
    .hit1          (hit1),
    .target0       (target0),
    .target1       (target1),
    .retire_valid  (retire_valid),
    .retire_mispred(retire_mispred),
    .retire_target (retire_target),
    .retire_ght    (retire_ght),
    .cur_ip        (cur_ip),
    .cur_ght       (cur_ght),
    .fetch_src     (fetch_src)
  );

  assign fetch_ip = cur_ip;
  assign fetch_ght = cur_ght;

endmodule

`default_nettype wire

/* verif/fetch_unit_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_asserts
  import fetch_pkg::*;
  import predict_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst,
  input wire logic  fetch_adv,
  input wire logic  retire_valid,
  input wire logic  retire_mispred,
  input wire addr_t retire_target,
  input wire addr_t cur_ip,
  input wire hist_t cur_ght
);

  logic redirect;

  assign redirect = retire_valid && retire_mispred;

  // fetch blocks are 16 bytes
  a_ip_aligned: assert property (@(posedge clk) disable iff (rst)
    cur_ip[BLOCK_SHIFT-1:0] == '0)
    else $error("fetch address is not block aligned");

  a_hold: assert property (@(posedge clk) disable iff (rst)
    !fetch_adv && !redirect |=> $stable(cur_ip) && $stable(cur_ght))
    else $error("fetch address or history moved while idle");

  a_redirect: assert property (@(posedge clk) disable iff (rst)
    redirect |=> cur_ip == $past(retire_target))
    else $error("mispredict did not load the retire target");

endmodule

bind next_ip_select fetch_unit_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .fetch_adv     (fetch_adv),
  .retire_valid  (retire_valid),
  .retire_mispred(retire_mispred),
  .retire_target (retire_target),
  .cur_ip        (cur_ip),
  .cur_ght       (cur_ght)
);

`default_nettype wire

/* verif/fetch_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;
  import fetch_pkg::*;
  import predict_pkg::*;

  localparam int    PRED_IDX_W = 10;
  localparam int    TB_IDX_W   = 6;
  localparam addr_t RESET_IP   = 32'h0000_1000;
  localparam int    TAG_W      = ADDR_W - BLOCK_SHIFT - TB_IDX_W;
  localparam int    HA         = PRED_IDX_W / 2;
  localparam int    HH         = PRED_IDX_W - HA;

  logic      clk;
  logic      rst;
  logic      fetch_adv;
  logic      retire_valid;
  addr_t     retire_ip;
  hist_t     retire_ght;
  logic      retire_way;
  addr_t     retire_target;
  logic      retire_mispred;
  addr_t     fetch_ip;
  hist_t     fetch_ght;
  next_src_e fetch_src;

  // reference model state
  logic [1:0]       tab_a [2**PRED_IDX_W];
  logic [1:0]       tab_b [2**PRED_IDX_W];
  logic [1:0]       tab_c [2**PRED_IDX_W];
  logic             bvalid [2][2**TB_IDX_W];
  logic [TAG_W-1:0] btag [2][2**TB_IDX_W];
  addr_t            btgt [2][2**TB_IDX_W];
  addr_t            m_ip;
  hist_t            m_ght;
  next_src_e        m_src;
  int               m_rot;
  int               errors;
  int               checks;

  // index 0 and 3 share a buffer set with different tags
  addr_t pool [8] = '{32'h1000, 32'h1010, 32'h1020, 32'h1400,
                      32'h2000, 32'h2010, 32'h11000, 32'h11010};

  fetch_unit #(.PRED_IDX_W(PRED_IDX_W), .TB_IDX_W(TB_IDX_W), .RESET_IP(RESET_IP)) u_dut (.*);

  always #50 clk = ~clk;

  function automatic logic [PRED_IDX_W-1:0] hash_a(addr_t ip, hist_t ght);
    return {ip[BLOCK_SHIFT +: PRED_IDX_W-2], ght[1:0]};
  endfunction

  function automatic logic [PRED_IDX_W-1:0] hash_b(addr_t ip, hist_t ght);
    return {ip[BLOCK_SHIFT +: HA], ght[HH-1:0]};
  endfunction

  function automatic logic [PRED_IDX_W-1:0] hash_c(addr_t ip, hist_t ght);
    return {ip[BLOCK_SHIFT +: 2], ght[PRED_IDX_W-3:0]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic expect_state(input string name, input addr_t ip, input hist_t ght,
                              input next_src_e src);
    compare_value({name, " ip"}, ip, fetch_ip);
    compare_value({name, " ght"}, 32'(ght), 32'(fetch_ght));
    compare_value({name, " src"}, 32'(src), 32'(fetch_src));
  endtask

  task automatic model_reset();
    for (int i = 0; i < 2**PRED_IDX_W; i++) begin
      tab_a[i] = 2'b00;
      tab_b[i] = 2'b00;
      tab_c[i] = 2'b00;
    end
    for (int w = 0; w < 2; w++) begin
      for (int i = 0; i < 2**TB_IDX_W; i++) begin
        bvalid[w][i] = 1'b0;
      end
    end
    m_ip = RESET_IP;
    m_ght = '0;
    m_src = src_seq;
    m_rot = 0;
  endtask

  // lookups see the state before this cycle's writes
  task automatic model_step();
    logic [1:0]            p;
    logic                  h0;
    logic                  h1;
    logic [TB_IDX_W-1:0]   bi;
    logic [PRED_IDX_W-1:0] wi;
    logic [1:0]            fb;
    bi = m_ip[BLOCK_SHIFT +: TB_IDX_W];
    p = tab_a[hash_a(m_ip, m_ght)] ^ tab_b[hash_b(m_ip, m_ght)] ^ tab_c[hash_c(m_ip, m_ght)];
    h0 = bvalid[0][bi] && (btag[0][bi] == m_ip[ADDR_W-1 -: TAG_W]);
    h1 = bvalid[1][bi] && (btag[1][bi] == m_ip[ADDR_W-1 -: TAG_W]);
    if (retire_valid && retire_mispred) begin
      m_ip = retire_target;
      m_ght = retire_ght;
      m_src = src_seq;
    end else if (fetch_adv) begin
      if (p[0] && h0) begin
        m_ip = btgt[0][bi];
        m_ght = {m_ght[HIST_W-2:0], 1'b1};
        m_src = src_way0;
      end else if (p[1] && h1) begin
        m_ip = btgt[1][bi];
        m_ght = {m_ght[HIST_W-3:0], 2'b01};
        m_src = src_way1;
      end else begin
        m_ip = m_ip + 32'd16;
        m_ght = {m_ght[HIST_W-3:0], 2'b00};
        m_src = src_seq;
      end
    end
    if (retire_valid) begin
      bi = retire_ip[BLOCK_SHIFT +: TB_IDX_W];
      bvalid[retire_way][bi] = 1'b1;
      btag[retire_way][bi] = retire_ip[ADDR_W-1 -: TAG_W];
      btgt[retire_way][bi] = retire_target;
    end
    if (retire_valid && retire_mispred) begin
      fb = retire_way ? 2'b10 : 2'b01;
      case (m_rot)
        0: begin
          wi = hash_a(retire_ip, retire_ght);
          tab_a[wi] = tab_a[wi] ^ fb;
        end
        1: begin
          wi = hash_b(retire_ip, retire_ght);
          tab_b[wi] = tab_b[wi] ^ fb;
        end
        default: begin
          wi = hash_c(retire_ip, retire_ght);
          tab_c[wi] = tab_c[wi] ^ fb;
        end
      endcase
      m_rot = (m_rot + 1) % 3;
    end
  endtask

  task automatic drive_cycle(input string name, input logic adv, input logic rv, input addr_t rip,
                             input hist_t rght, input logic rway, input addr_t rtgt,
                             input logic rmis);
    fetch_adv = adv;
    retire_valid = rv;
    retire_ip = rip;
    retire_ght = rght;
    retire_way = rway;
    retire_target = rtgt;
    retire_mispred = rmis;
    model_step();
    @(posedge clk);
    #1;
    expect_state(name, m_ip, m_ght, m_src);
  endtask

  task automatic wait_reset_state();
    int n;
    n = 0;
    while (n < 16 && (fetch_ip !== RESET_IP || fetch_ght !== '0 || fetch_src !== src_seq)) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n >= 16) begin
      $display("timeout: the fetch unit never showed its reset state");
      $display("TESTBENCH FAILED");
      $finish;
    end
  endtask

  initial begin
    addr_t       ip0;
    addr_t       ip1;
    hist_t       g0;
    hist_t       g1;
    logic        adv;
    logic        rv;
    logic        rmis;
    logic [2:0]  k;
    addr_t       rip;
    addr_t       rtgt;
    hist_t       rght;
    clk = 1'b0;
    rst = 1'b1;
    fetch_adv = 1'b0;
    retire_valid = 1'b0;
    retire_ip = '0;
    retire_ght = '0;
    retire_way = 1'b0;
    retire_target = '0;
    retire_mispred = 1'b0;
    errors = 0;
    checks = 0;
    void'($urandom(32'h1d68b3a4));
    model_reset();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_reset_state();
    expect_state("reset", RESET_IP, '0, src_seq);
    repeat (3) drive_cycle("sequential", 1'b1, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_state("sequential", RESET_IP + 32'd48, '0, src_seq);

    // way 0 training, then come back to the same block and history
    ip0 = fetch_ip;
    g0 = fetch_ght;
    drive_cycle("train0", 1'b0, 1'b1, ip0, g0, 1'b0, 32'h2340, 1'b1);
    drive_cycle("return0", 1'b0, 1'b1, 32'h3050, g0, 1'b1, ip0, 1'b1);
    drive_cycle("jump0", 1'b1, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_state("jump0", 32'h2340, {g0[HIST_W-2:0], 1'b1}, src_way0);

    ip1 = fetch_ip;
    g1 = fetch_ght;
    drive_cycle("train1", 1'b0, 1'b1, ip1, g1, 1'b1, 32'h4560, 1'b1);
    drive_cycle("return1", 1'b0, 1'b1, 32'h3050, g1, 1'b0, ip1, 1'b1);
    drive_cycle("jump1", 1'b1, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_state("jump1", 32'h4560, {g1[HIST_W-3:0], 2'b01}, src_way1);

    // same predictor and buffer index as ip0, other tag
    drive_cycle("alias", 1'b0, 1'b1, 32'h3050, g0, 1'b1, ip0 | 32'h0001_0000, 1'b1);
    drive_cycle("alias step", 1'b1, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    expect_state("alias", (ip0 | 32'h0001_0000) + 32'd16, {g0[HIST_W-3:0], 2'b00}, src_seq);

    // back at ip0 so that fetch_adv alone would take the way 0 jump
    drive_cycle("rewind", 1'b0, 1'b1, 32'h3050, g0, 1'b1, ip0, 1'b1);
    drive_cycle("redirect", 1'b1, 1'b1, 32'h3050, 14'h2a5, 1'b0, 32'h5670, 1'b1);
    expect_state("redirect", 32'h5670, 14'h2a5, src_seq);

    for (int i = 0; i < 3000; i++) begin
      adv = ($urandom % 4) != 0;
      rv = ($urandom % 4) == 0;
      rmis = rv && (($urandom % 3) == 0);
      k = 3'($urandom);
      rip = (($urandom % 2) == 0) ? m_ip : pool[k];
      rght = (($urandom % 2) == 0) ? m_ght : hist_t'($urandom);
      k = 3'($urandom);
      rtgt = pool[k];
      drive_cycle("random", adv, rv, rip, rght, 1'($urandom), rtgt, rmis);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hdl/fetch_pkg.sv
hdl/predict_pkg.sv
hdl/dir_predictor.sv
hdl/target_buffer.sv
hdl/next_ip_select.sv
hdl/fetch_unit.sv
verif/fetch_unit_asserts.sv
verif/fetch_unit_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fetch_unit_tb -f flist.f \
		--Mdir obj_dir -o fetch_unit_tb
	./obj_dir/fetch_unit_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
